// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int WORD_W     = 16;
	localparam int IMEM_DEPTH = 64;
	localparam int NUM_REGS   = 8;

	typedef logic [WORD_W-1:0]             word_t;
	typedef logic [$clog2(NUM_REGS)-1:0]   reg_addr_t;
	typedef logic [$clog2(IMEM_DEPTH)-1:0] pc_t;

	// fields are op rd rs rt from the top bit down
	// imm6 and offset6 sit in the low six bits, imm8 in the low byte
	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_AND  = 4'd3,
		OP_OR   = 4'd4,
		OP_XOR  = 4'd5,
		OP_SLL  = 4'd6,
		OP_SRL  = 4'd7,
		OP_SLT  = 4'd8,
		OP_ADDI = 4'd9,
		OP_LI   = 4'd10,
		OP_BEQZ = 4'd11,
		OP_BNEZ = 4'd12,
		OP_HALT = 4'd15
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SLT,
		ALU_ADDI,
		ALU_LI
	} alu_op_e;

	typedef struct packed {
		alu_op_e   alu_op;
		logic      we;
		reg_addr_t rd;
		reg_addr_t ra;
		reg_addr_t rb;
		logic      uses_a;
		logic      uses_b;
		word_t     imm;
		logic      use_imm;
		logic      br_zero;
		logic      br_nonzero;
		pc_t       offset;
		logic      halt;
	} ctrl_t;

	typedef struct packed {
		logic      valid;
		alu_op_e   alu_op;
		logic      we;
		reg_addr_t rd;
		word_t     a;
		word_t     b;
		logic      halt;
	} exe_t;

	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		word_t     value;
	} wb_t;

	// segment bits in gfedcba order, 1 lights the segment
	function automatic logic [6:0] seg_encode(input logic [3:0] nibble);
		logic [6:0] seg;
		case (nibble)
			4'h0: seg = 7'h3f;
			4'h1: seg = 7'h06;
			4'h2: seg = 7'h5b;
			4'h3: seg = 7'h4f;
			4'h4: seg = 7'h66;
			4'h5: seg = 7'h6d;
			4'h6: seg = 7'h7d;
			4'h7: seg = 7'h07;
			4'h8: seg = 7'h7f;
			4'h9: seg = 7'h6f;
			4'ha: seg = 7'h77;
			4'hb: seg = 7'h7c;
			4'hc: seg = 7'h39;
			4'hd: seg = 7'h5e;
			4'he: seg = 7'h79;
			default: seg = 7'h71;
		endcase
		return seg;
	endfunction

endpackage

`default_nettype wire

// File: fetch_stage.sv
`default_nettype none

module fetch_stage import cpu_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  run,
	input  logic  load_en,
	input  pc_t   load_addr,
	input  word_t load_data,
	input  logic  hold,
	input  logic  stop,
	input  logic  redirect,
	input  pc_t   redirect_pc,
	output word_t if_inst,
	output pc_t   if_pc,
	output logic  if_valid
);

	pc_t   pc;
	word_t imem [IMEM_DEPTH];
	logic  stopped;
	logic  frozen;

	// once halt was seen the pc stays put until run drops
	assign frozen = hold || stop || stopped;

	// load port stands in for a bootloader
	always_ff @(posedge clk) begin
		if (load_en && !run) begin
			imem[load_addr] <= load_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc      <= '0;
			stopped <= 1'b0;
		end else if (!run) begin
			pc      <= '0;
			stopped <= 1'b0;
		end else begin
			if (stop) begin
				stopped <= 1'b1;
			end
			if (redirect) begin
				pc <= redirect_pc;
			end else if (!frozen) begin
				pc <= pc + pc_t'(1);
			end
		end
	end

	// if/id valid, a redirect or halt squashes the younger fetch
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_valid <= 1'b0;
		end else if (!run || redirect || stop || stopped) begin
			if_valid <= 1'b0;
		end else if (!hold) begin
			if_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			if_inst <= imem[pc];
			if_pc   <= pc;
		end
	end

endmodule

`default_nettype wire

// File: decoder.sv
`default_nettype none

module decoder import cpu_pkg::*; (
	input  word_t inst,
	output ctrl_t ctrl
);

	opcode_e   op;
	reg_addr_t rd;
	reg_addr_t rs;
	reg_addr_t rt;

	assign op = opcode_e'(inst[15:12]);
	assign rd = inst[11:9];
	assign rs = inst[8:6];
	assign rt = inst[5:3];

	always_comb begin
		// unused opcodes fall through as nop
		ctrl        = '0;
		ctrl.rd     = rd;
		ctrl.ra     = rs;
		ctrl.rb     = rt;
		ctrl.offset = inst[5:0];

		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SLT: begin
				ctrl.we     = 1'b1;
				ctrl.uses_a = 1'b1;
				ctrl.uses_b = 1'b1;
			end
			OP_ADDI: begin
				ctrl.we      = 1'b1;
				ctrl.uses_a  = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.imm     = {{10{inst[5]}}, inst[5:0]};
			end
			OP_LI: begin
				ctrl.we      = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.imm     = {8'h00, inst[7:0]};
			end
			OP_BEQZ: begin
				ctrl.uses_a  = 1'b1;
				ctrl.br_zero = 1'b1;
			end
			OP_BNEZ: begin
				ctrl.uses_a     = 1'b1;
				ctrl.br_nonzero = 1'b1;
			end
			OP_HALT: begin
				ctrl.halt = 1'b1;
			end
			default: begin
			end
		endcase

		case (op)
			OP_SUB:  ctrl.alu_op = ALU_SUB;
			OP_AND:  ctrl.alu_op = ALU_AND;
			OP_OR:   ctrl.alu_op = ALU_OR;
			OP_XOR:  ctrl.alu_op = ALU_XOR;
			OP_SLL:  ctrl.alu_op = ALU_SLL;
			OP_SRL:  ctrl.alu_op = ALU_SRL;
			OP_SLT:  ctrl.alu_op = ALU_SLT;
			OP_ADDI: ctrl.alu_op = ALU_ADDI;
			OP_LI:   ctrl.alu_op = ALU_LI;
			default: ctrl.alu_op = ALU_ADD;
		endcase

		// r0 is hardwired, drop the write here
		ctrl.we = ctrl.we && (rd != '0);
	end

endmodule

`default_nettype wire

// File: decode_stage.sv
`default_nettype none

module decode_stage import cpu_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      run,
	input  word_t     if_inst,
	input  pc_t       if_pc,
	input  logic      if_valid,
	input  logic      hold,
	output reg_addr_t rd_addr_a,
	output reg_addr_t rd_addr_b,
	input  word_t     rd_value_a,
	input  word_t     rd_value_b,
	output reg_addr_t src_a,
	output reg_addr_t src_b,
	output logic      uses_a,
	output logic      uses_b,
	output logic      redirect,
	output pc_t       redirect_pc,
	output logic      stop,
	output exe_t      exe
);

	ctrl_t ctrl;
	logic  issue;
	logic  is_zero;

	decoder u_decoder (
		.inst(if_inst),
		.ctrl(ctrl)
	);

	assign rd_addr_a = ctrl.ra;
	assign rd_addr_b = ctrl.rb;
	assign src_a     = ctrl.ra;
	assign src_b     = ctrl.rb;
	assign uses_a    = if_valid && ctrl.uses_a;
	assign uses_b    = if_valid && ctrl.uses_b;

	// branch resolves in id on the rs value
	assign issue       = if_valid && !hold;
	assign is_zero     = (rd_value_a == '0);
	assign redirect    = issue && ((ctrl.br_zero && is_zero) || (ctrl.br_nonzero && !is_zero));
	assign redirect_pc = if_pc + pc_t'(1) + ctrl.offset;
	assign stop        = issue && ctrl.halt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exe <= '0;
		end else if (!run || !issue) begin
			// bubble
			exe <= '0;
		end else begin
			exe.valid  <= 1'b1;
			exe.alu_op <= ctrl.alu_op;
			exe.we     <= ctrl.we;
			exe.rd     <= ctrl.rd;
			exe.a      <= rd_value_a;
			exe.b      <= ctrl.use_imm ? ctrl.imm : rd_value_b;
			exe.halt   <= ctrl.halt;
		end
	end

	a_redirect_stop_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(redirect && stop));

endmodule

`default_nettype wire

// File: register_file.sv
`default_nettype none

module register_file import cpu_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  reg_addr_t rd_addr_a,
	input  reg_addr_t rd_addr_b,
	output word_t     rd_value_a,
	output word_t     rd_value_b,
	input  wb_t       wb
);

	word_t regs [NUM_REGS];

	// write-through so a writer in exe/wb never needs a stall
	function automatic word_t read_reg(input reg_addr_t addr, input word_t stored,
			input wb_t wr);
		word_t value;
		if (addr == '0) begin
			value = '0;
		end else if (wr.en && wr.addr == addr) begin
			value = wr.value;
		end else begin
			value = stored;
		end
		return value;
	endfunction

	always_comb begin
		rd_value_a = read_reg(rd_addr_a, regs[rd_addr_a], wb);
		rd_value_b = read_reg(rd_addr_b, regs[rd_addr_b], wb);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.en && wb.addr != '0) begin
			regs[wb.addr] <= wb.value;
		end
	end

endmodule

`default_nettype wire

// File: hazard_ctrl.sv
`default_nettype none

module hazard_ctrl import cpu_pkg::*; (
	input  reg_addr_t src_a,
	input  reg_addr_t src_b,
	input  logic      uses_a,
	input  logic      uses_b,
	input  exe_t      exe,
	output logic      hold
);

	logic pending;
	logic hit_a;
	logic hit_b;

	// only the writer in execute matters, exe/wb is covered by write-through
	assign pending = exe.valid && exe.we;
	assign hit_a   = uses_a && (src_a != '0) && (src_a == exe.rd);
	assign hit_b   = uses_b && (src_b != '0) && (src_b == exe.rd);
	assign hold    = pending && (hit_a || hit_b);

endmodule

`default_nettype wire

// File: execute_stage.sv
`default_nettype none

module execute_stage import cpu_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic run,
	input  exe_t exe,
	output wb_t  wb,
	output logic halted
);

	word_t alu_res;

	always_comb begin
		case (exe.alu_op)
			ALU_SUB: alu_res = exe.a - exe.b;
			ALU_AND: alu_res = exe.a & exe.b;
			ALU_OR:  alu_res = exe.a | exe.b;
			ALU_XOR: alu_res = exe.a ^ exe.b;
			// shift amount is the low nibble of rt
			ALU_SLL: alu_res = exe.a << exe.b[3:0];
			ALU_SRL: alu_res = exe.a >> exe.b[3:0];
			ALU_SLT: alu_res = {15'h0000, ($signed(exe.a) < $signed(exe.b))};
			ALU_LI:  alu_res = exe.b;
			default: alu_res = exe.a + exe.b;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb     <= '0;
			halted <= 1'b0;
		end else begin
			wb.en    <= run && exe.valid && exe.we;
			wb.addr  <= exe.rd;
			wb.value <= alu_res;
			// sticky until run drops
			if (!run) begin
				halted <= 1'b0;
			end else if (exe.valid && exe.halt) begin
				halted <= 1'b1;
			end
		end
	end

	a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
		wb.en |-> wb.addr != '0);

	// fetch and decode must have squashed everything behind the halt
	a_quiet_after_halt: assert property (@(posedge clk) disable iff (!arst_n)
		halted |=> !wb.en);

endmodule

`default_nettype wire

// File: debug_display.sv
`default_nettype none

module debug_display import cpu_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  wb_t        wb,
	output word_t      led,
	output logic [6:0] seg1,
	output logic [6:0] seg2
);

	reg_addr_t last_addr;
	word_t     last_value;

	// keep the most recent register write on show
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last_addr  <= '0;
			last_value <= '0;
		end else if (wb.en) begin
			last_addr  <= wb.addr;
			last_value <= wb.value;
		end
	end

	assign led = last_value;

	// address on the first digit, low nibble of the value on the second
	assign seg1 = seg_encode({1'b0, last_addr});
	assign seg2 = seg_encode(last_value[3:0]);

endmodule

`default_nettype wire

// File: cpu_top.sv
`default_nettype none

module cpu_top import cpu_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       run,
	input  logic       load_en,
	input  pc_t        load_addr,
	input  word_t      load_data,
	output wb_t        wb_trace,
	output logic       halted,
	output word_t      led,
	output logic [6:0] seg1,
	output logic [6:0] seg2
);

	// if stage
	word_t     if_inst;
	pc_t       if_pc;
	logic      if_valid;

	// id stage and its feedback to fetch
	logic      redirect;
	pc_t       redirect_pc;
	logic      stop;
	reg_addr_t rd_addr_a;
	reg_addr_t rd_addr_b;
	word_t     rd_value_a;
	word_t     rd_value_b;

	// stall control
	reg_addr_t src_a;
	reg_addr_t src_b;
	logic      uses_a;
	logic      uses_b;
	logic      hold;

	exe_t      exe;

	fetch_stage u_fetch (
		.clk(clk),
		.arst_n(arst_n),
		.run(run),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.hold(hold),
		.stop(stop),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.if_inst(if_inst),
		.if_pc(if_pc),
		.if_valid(if_valid)
	);

	decode_stage u_decode (
		.clk(clk),
		.arst_n(arst_n),
		.run(run),
		.if_inst(if_inst),
		.if_pc(if_pc),
		.if_valid(if_valid),
		.hold(hold),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_value_a(rd_value_a),
		.rd_value_b(rd_value_b),
		.src_a(src_a),
		.src_b(src_b),
		.uses_a(uses_a),
		.uses_b(uses_b),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.stop(stop),
		.exe(exe)
	);

	register_file u_regs (
		.clk(clk),
		.arst_n(arst_n),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_value_a(rd_value_a),
		.rd_value_b(rd_value_b),
		.wb(wb_trace)
	);

	hazard_ctrl u_hazard (
		.src_a(src_a),
		.src_b(src_b),
		.uses_a(uses_a),
		.uses_b(uses_b),
		.exe(exe),
		.hold(hold)
	);

	execute_stage u_execute (
		.clk(clk),
		.arst_n(arst_n),
		.run(run),
		.exe(exe),
		.wb(wb_trace),
		.halted(halted)
	);

	debug_display u_display (
		.clk(clk),
		.arst_n(arst_n),
		.wb(wb_trace),
		.led(led),
		.seg1(seg1),
		.seg2(seg2)
	);

endmodule

`default_nettype wire

// File: tb_cpu_top.sv
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TESTS = 8;
	localparam int PROG_LEN  = 24;
	localparam int MAX_WAIT  = 1000;

	logic       clk = 1'b0;
	logic       arst_n;
	logic       run;
	logic       load_en;
	pc_t        load_addr;
	word_t      load_data;
	wb_t        wb_trace;
	logic       halted;
	word_t      led;
	logic [6:0] seg1;
	logic [6:0] seg2;

	logic [31:0] lfsr_state;
	word_t       program_mem [IMEM_DEPTH];
	word_t       model_regs [NUM_REGS];
	reg_addr_t   last_addr;
	word_t       last_value;
	wb_t         expected [$];
	int          write_count = 0;

	cpu_top dut0 (
		.clk(clk),
		.arst_n(arst_n),
		.run(run),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.wb_trace(wb_trace),
		.halted(halted),
		.led(led),
		.seg1(seg1),
		.seg2(seg2)
	);

	always #4 clk = ~clk;

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic logic [15:0] take_bits(input int count);
		logic [15:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[14:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	// segments in gfedcba order with a 1 lighting one
	function automatic logic [6:0] seg_pattern(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'b0111111;
			4'h1: return 7'b0000110;
			4'h2: return 7'b1011011;
			4'h3: return 7'b1001111;
			4'h4: return 7'b1100110;
			4'h5: return 7'b1101101;
			4'h6: return 7'b1111101;
			4'h7: return 7'b0000111;
			4'h8: return 7'b1111111;
			4'h9: return 7'b1101111;
			4'ha: return 7'b1110111;
			4'hb: return 7'b1111100;
			4'hc: return 7'b0111001;
			4'hd: return 7'b1011110;
			4'he: return 7'b1111001;
			default: return 7'b1110001;
		endcase
	endfunction

	function automatic void gen_program();
		logic [3:0] op;
		reg_addr_t  rd;
		reg_addr_t  rs;
		reg_addr_t  rt;
		logic [2:0] low;
		// halt fill with the address in the low bits
		for (int i = 0; i < IMEM_DEPTH; i++) begin
			program_mem[i] = {OP_HALT, 6'h00, pc_t'(i)};
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			op  = 4'(take_bits(4));
			rd  = reg_addr_t'(take_bits(3));
			rs  = reg_addr_t'(take_bits(3));
			rt  = reg_addr_t'(take_bits(3));
			low = 3'(take_bits(3));
			// halt only in the tail
			if (op == OP_HALT) begin
				op = OP_LI;
			end
			// branches jump forward by 0 to 7
			if (op == OP_BEQZ || op == OP_BNEZ) begin
				rt = '0;
			end
			program_mem[i] = {op, rd, rs, rt, low};
		end
	endfunction

	// ISA model that keeps register state across programs
	function automatic void run_model();
		pc_t   pc;
		word_t inst;
		word_t a;
		word_t b;
		word_t res;
		logic  we;
		logic  done;
		wb_t   w;
		pc = '0;
		done = 1'b0;
		for (int step = 0; step < 4 * IMEM_DEPTH && !done; step++) begin
			inst = program_mem[pc];
			a = model_regs[inst[8:6]];
			b = model_regs[inst[5:3]];
			we = 1'b1;
			res = '0;
			pc = pc + pc_t'(1);
			case (inst[15:12])
				OP_ADD:  res = a + b;
				OP_SUB:  res = a - b;
				OP_AND:  res = a & b;
				OP_OR:   res = a | b;
				OP_XOR:  res = a ^ b;
				OP_SLL:  res = a << b[3:0];
				OP_SRL:  res = a >> b[3:0];
				OP_SLT:  res = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
				OP_ADDI: res = a + {{10{inst[5]}}, inst[5:0]};
				OP_LI:   res = {8'h00, inst[7:0]};
				OP_BEQZ, OP_BNEZ: begin
					we = 1'b0;
					if ((a == '0) == (inst[15:12] == OP_BEQZ)) begin
						pc = pc + pc_t'(inst[5:0]);
					end
				end
				OP_HALT: begin
					we = 1'b0;
					done = 1'b1;
				end
				default: we = 1'b0;
			endcase
			if (we && inst[11:9] != 3'd0) begin
				model_regs[inst[11:9]] = res;
				last_addr = inst[11:9];
				last_value = res;
				w.en = 1'b1;
				w.addr = inst[11:9];
				w.value = res;
				expected.push_back(w);
			end
		end
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_wb(input wb_t got, input wb_t want, input string what);
		if (got !== want) begin
			abort_run($sformatf("[ERROR] %0d ns %s: got en=%0b r%0d=%h, expected en=%0b r%0d=%h",
				$time, what, got.en, got.addr, got.value, want.en, want.addr, want.value));
		end
	endtask

	task automatic check_word(input word_t got, input word_t want, input string what);
		if (got !== want) begin
			abort_run($sformatf("[ERROR] %0d ns %s: got %h, expected %h",
				$time, what, got, want));
		end
	endtask

	task automatic check_seg(input logic [6:0] got, input logic [6:0] want, input string what);
		if (got !== want) begin
			abort_run($sformatf("[ERROR] %0d ns %s: got %b, expected %b",
				$time, what, got, want));
		end
	endtask

	task automatic load_program();
		for (int i = 0; i < IMEM_DEPTH; i++) begin
			@(negedge clk);
			load_en = 1'b1;
			load_addr = pc_t'(i);
			load_data = program_mem[i];
		end
		@(negedge clk);
		load_en = 1'b0;
	endtask

	// each write-back is the next modeled write and none follows halted
	always @(negedge clk) begin
		if (arst_n && wb_trace.en) begin
			if (halted) begin
				abort_run($sformatf("[ERROR] %0d ns write r%0d=%h after halted",
					$time, wb_trace.addr, wb_trace.value));
			end else if (expected.size() == 0) begin
				abort_run($sformatf("[ERROR] %0d ns unexpected write r%0d=%h",
					$time, wb_trace.addr, wb_trace.value));
			end else begin
				check_wb(wb_trace, expected.pop_front(), $sformatf("write %0d", write_count));
				write_count++;
			end
		end
	end

	initial begin
		int cycles;
		arst_n = 1'b0;
		run = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		lfsr_state = 32'h947f;
		last_addr = '0;
		last_value = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		repeat (2) @(negedge clk);
		check_wb(wb_trace, '0, "wb_trace in reset");
		if (halted !== 1'b0) begin
			abort_run("halted was not low during reset");
		end
		repeat (2) @(negedge clk);
		arst_n = 1'b1;

		for (int t = 0; t < NUM_TESTS; t++) begin
			gen_program();
			run_model();
			load_program();
			run = 1'b1;
			cycles = 0;
			while (!halted && cycles < MAX_WAIT) begin
				@(negedge clk);
				cycles++;
			end
			if (!halted) begin
				abort_run($sformatf("program %0d: halted never came within %0d cycles",
					t, MAX_WAIT));
			end
			// let the pipeline drain before the final checks
			repeat (4) @(negedge clk);
			@(posedge clk);
			if (expected.size() != 0) begin
				abort_run($sformatf("[ERROR] %0d ns program %0d: %0d modeled writes missing",
					$time, t, expected.size()));
			end
			@(negedge clk);
			if (halted !== 1'b1) begin
				abort_run($sformatf("program %0d: halted fell while run was still high", t));
			end
			check_word(led, last_value, "led");
			check_seg(seg1, seg_pattern({1'b0, last_addr}), "seg1");
			check_seg(seg2, seg_pattern(last_value[3:0]), "seg2");
			run = 1'b0;
			repeat (2) @(negedge clk);
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: cpu_top.f
cpu_pkg.sv
fetch_stage.sv
decoder.sv
decode_stage.sv
register_file.sv
hazard_ctrl.sv
execute_stage.sv
debug_display.sv
cpu_top.sv
tb_cpu_top.sv
